//--- apb_i2c.f
apb_types_pkg.sv
i2c_pkg.sv
apb_slave_port.sv
i2c_regs.sv
i2c_bit_timer.sv
i2c_master_fsm.sv
apb_i2c.sv
i2c_target_model.sv
apb_i2c_sva.sv
tb_apb_i2c.sv

//--- apb_i2c.sv
//##################
// APB I2C master
// Single-master I2C controller on an APB slave port
//##################
`default_nettype none

module apb_i2c (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  apb_types_pkg::apb_in_t  i_apb,
    output apb_types_pkg::apb_out_t o_apb,
    output logic                    o_scl,
    output logic                    o_sda,
    output logic                    o_sda_dir,
    input  logic                    i_sda,
    output logic                    o_irq
);

    import apb_types_pkg::*;
    import i2c_pkg::*;

    logic      req_valid;
    logic      req_write;
    apb_addr_t req_addr;
    apb_data_t req_wdata;
    logic      resp_valid;
    apb_data_t resp_rdata;
    i2c_ctrl_t ctrl;
    i2c_done_t done;
    scale_t    scaler;
    scale_t    setup_time;
    logic      busy;
    logic      change;
    logic      latch;

    apb_slave_port u_port (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_apb        (i_apb),
        .o_apb        (o_apb),
        .o_req_valid  (req_valid),
        .o_req_write  (req_write),
        .o_req_addr   (req_addr),
        .o_req_wdata  (req_wdata),
        .i_resp_valid (resp_valid),
        .i_resp_rdata (resp_rdata)
    );

    i2c_regs u_regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (req_valid),
        .i_req_write  (req_write),
        .i_req_addr   (req_addr),
        .i_req_wdata  (req_wdata),
        .o_resp_valid (resp_valid),
        .o_resp_rdata (resp_rdata),
        .i_done       (done),
        .o_ctrl       (ctrl),
        .o_scaler     (scaler),
        .o_setup_time (setup_time),
        .o_irq        (o_irq),
        .i_sda        (i_sda)
    );

    i2c_bit_timer u_timer (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_scaler     (scaler),
        .i_setup_time (setup_time),
        .i_busy       (busy),
        .o_scl        (o_scl),
        .o_change     (change),
        .o_latch      (latch)
    );

    i2c_master_fsm u_engine (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_ctrl    (ctrl),
        .i_change  (change),
        .i_latch   (latch),
        .i_sda     (i_sda),
        .o_busy    (busy),
        .o_sda     (o_sda),
        .o_sda_dir (o_sda_dir),
        .o_done    (done)
    );

endmodule

`default_nettype wire

//--- apb_i2c_sva.sv
//##################
// I2C bus checks
// SCL/SDA idle levels, START/STOP only edges and irq
//##################
`default_nettype none

module apb_i2c_sva (
    input logic i_clk,
    input logic i_nrst,
    input logic i_scl,
    input logic i_sda,   // Bus level
    input logic i_busy,
    input logic i_ie,
    input logic i_irq
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    idle_lines: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !i_busy |-> i_scl && i_sda)
    else begin
        fail_count++;
        $error("SCL or SDA low while idle");
    end

    // SDA may fall under a high SCL only as START
    start_only: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_scl && $past(i_scl) && $fell(i_sda)) |-> (i_busy && !$past(i_busy)))
    else begin
        fail_count++;
        $error("SDA fell while SCL high outside START");
    end

    // SDA may rise under a high SCL only as STOP
    stop_only: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_scl && $past(i_scl) && $rose(i_sda)) |-> (!i_busy && $past(i_busy)))
    else begin
        fail_count++;
        $error("SDA rose while SCL high outside STOP");
    end

    irq_after_reset: assert property (@(posedge i_clk)
        $rose(i_nrst) |-> !i_irq)
    else begin
        fail_count++;
        $error("irq high out of reset");
    end

    irq_needs_ie: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_irq) |-> $past(i_ie))
    else begin
        fail_count++;
        $error("irq rose with ie clear");
    end

endmodule

`default_nettype wire

//--- apb_slave_port.sv
//##################
// APB slave port
// Turns each APB access into one register request
// and returns the registered answer with one wait state
//##################
`default_nettype none

module apb_slave_port (
    input  logic                     i_clk,
    input  logic                     i_nrst,
    input  apb_types_pkg::apb_in_t   i_apb,
    output apb_types_pkg::apb_out_t  o_apb,
    output logic                     o_req_valid,
    output logic                     o_req_write,
    output apb_types_pkg::apb_addr_t o_req_addr,
    output apb_types_pkg::apb_data_t o_req_wdata,
    input  logic                     i_resp_valid,
    input  apb_types_pkg::apb_data_t i_resp_rdata
);

    logic access;   // Access phase
    logic pending;  // Request already issued for this access

    assign access      = i_apb.psel & i_apb.penable;
    assign o_req_valid = access & ~pending;
    assign o_req_write = i_apb.pwrite;
    assign o_req_addr  = i_apb.paddr;
    assign o_req_wdata = i_apb.pwdata;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pending <= 1'b0;
        end else if (o_req_valid) begin
            pending <= 1'b1;
        end else if (!access) begin
            pending <= 1'b0;  // Back in setup phase or bus idle
        end
    end

    // The register bank answers one cycle after the request
    assign o_apb.pready  = i_resp_valid;
    assign o_apb.prdata  = i_resp_rdata;
    assign o_apb.pslverr = 1'b0;

endmodule

`default_nettype wire

//--- apb_types_pkg.sv
//##################
// APB bus types
// Bus widths and the bridge/slave signal bundles
//##################
`default_nettype none

package apb_types_pkg;

    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;  // Byte address of one word
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // Bridge to slave
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_in_t;

    // Slave to bridge
    typedef struct packed {
        logic      pready;
        apb_data_t prdata;
        logic      pslverr;
    } apb_out_t;

endpackage

`default_nettype wire

//--- i2c_bit_timer.sv
//##################
// I2C bit timer
// Divides the system clock down to SCL and marks
// the data change and data latch points
//##################
`default_nettype none

module i2c_bit_timer (
    input  logic            i_clk,
    input  logic            i_nrst,
    input  i2c_pkg::scale_t i_scaler,
    input  i2c_pkg::scale_t i_setup_time,
    input  logic            i_busy,
    output logic            o_scl,
    output logic            o_change,
    output logic            o_latch
);

    import i2c_pkg::*;

    scale_t cnt;
    logic   scl;
    logic   run;        // Transfer active and divider set
    logic   half_end;   // Last cycle of a half period
    logic   setup_hit;

    assign run       = i_busy && (i_scaler != '0);
    assign half_end  = (cnt == scale_t'(i_scaler - 16'd1));
    assign setup_hit = run && !half_end && (cnt == i_setup_time);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt <= '0;
            scl <= 1'b1;
        end else if (!i_busy) begin
            // Bus idle keeps SCL released
            cnt <= '0;
            scl <= 1'b1;
        end else if (run) begin
            if (half_end) begin
                cnt <= '0;
                scl <= ~scl;
            end else begin
                cnt <= cnt + 16'd1;
            end
        end
    end

    assign o_scl    = scl;
    assign o_change = setup_hit & ~scl;  // SDA may move while SCL is low
    assign o_latch  = setup_hit & scl;   // SDA is stable while SCL is high

endmodule

`default_nettype wire

//--- i2c_master_fsm.sv
//##################
// I2C protocol engine
// Shifts out START, header and data bytes, samples
// ACKs and read data, and finishes with STOP
//##################
`default_nettype none

module i2c_master_fsm (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  i2c_pkg::i2c_ctrl_t i_ctrl,
    input  logic               i_change,
    input  logic               i_latch,
    input  logic               i_sda,
    output logic               o_busy,
    output logic               o_sda,
    output logic               o_sda_dir,
    output i2c_pkg::i2c_done_t o_done
);

    import i2c_pkg::*;

    i2c_state_e         state;
    logic [FRAME_W-1:0] shift;     // MSB drives SDA
    logic [2:0]         bit_cnt;   // Wraps back to 7 at each byte end
    byte_cnt_t          byte_cnt;  // Data bytes still to go
    logic               rnw;
    logic               ack;       // High means NACK
    logic               sda_dir;
    logic               err_ack_header;
    logic               err_ack_data;
    logic               done;
    logic               rx_valid;
    payload_t           payload;
    logic [7:0]         rx_byte;
    logic               go;
    logic               byte_end;

    assign go       = i_ctrl.start && (state == IDLE);  // Ignored while busy
    assign byte_end = i_change && (bit_cnt == 3'd0);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state          <= IDLE;
            shift          <= '1;
            bit_cnt        <= '0;
            byte_cnt       <= '0;
            rnw            <= 1'b0;
            ack            <= 1'b0;
            sda_dir        <= PIN_DIR_OUTPUT;
            err_ack_header <= 1'b0;
            err_ack_data   <= 1'b0;
            done           <= 1'b0;
            rx_valid       <= 1'b0;
        end else begin
            done     <= 1'b0;
            rx_valid <= 1'b0;
            if (i_change) begin
                shift <= {shift[FRAME_W-2:0], 1'b1};
            end
            case (state)
                IDLE: begin
                    if (go) begin
                        // Leading 0 pulls SDA low under a high SCL
                        shift          <= {1'b0, i_ctrl.addr, i_ctrl.rnw, 1'b1,
                                           i_ctrl.payload[7:0], 1'b1};
                        rnw            <= i_ctrl.rnw;
                        byte_cnt       <= i_ctrl.byte_cnt;
                        err_ack_header <= 1'b0;
                        err_ack_data   <= 1'b0;
                        state          <= START;
                    end
                end
                START: begin
                    if (i_change) begin
                        bit_cnt <= 3'd7;
                        state   <= HEADER;
                    end
                end
                HEADER: begin
                    if (i_change) begin
                        bit_cnt <= bit_cnt - 3'd1;
                        if (bit_cnt == 3'd0) begin
                            sda_dir <= PIN_DIR_INPUT;  // Target drives the ACK
                            state   <= ACK_HEADER;
                        end
                    end
                end
                ACK_HEADER: begin
                    if (i_latch) begin
                        ack <= i_sda;
                    end
                    if (i_change) begin
                        sda_dir <= PIN_DIR_OUTPUT;
                        if (ack || byte_cnt == '0) begin
                            err_ack_header <= ack;
                            shift          <= '0;  // Low ahead of STOP
                            state          <= STOP;
                        end else if (rnw) begin
                            sda_dir <= PIN_DIR_INPUT;
                            state   <= RX_DATA;
                        end else begin
                            state <= TX_DATA;
                        end
                    end
                end
                TX_DATA: begin
                    if (i_change) begin
                        bit_cnt <= bit_cnt - 3'd1;
                        if (bit_cnt == 3'd0) begin
                            sda_dir  <= PIN_DIR_INPUT;
                            byte_cnt <= byte_cnt - 4'd1;
                            state    <= WAIT_ACK_DATA;
                        end
                    end
                end
                WAIT_ACK_DATA: begin
                    if (i_latch) begin
                        ack <= i_sda;
                    end
                    if (i_change) begin
                        sda_dir <= PIN_DIR_OUTPUT;
                        if (ack || byte_cnt == '0) begin
                            err_ack_data <= ack;
                            shift        <= '0;
                            state        <= STOP;
                        end else begin
                            // Next payload byte, LSB byte first
                            shift <= {payload[7:0], {(FRAME_W-8){1'b1}}};
                            state <= TX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (i_change) begin
                        bit_cnt <= bit_cnt - 3'd1;
                        if (bit_cnt == 3'd0) begin
                            sda_dir  <= PIN_DIR_OUTPUT;
                            byte_cnt <= byte_cnt - 4'd1;
                            rx_valid <= 1'b1;
                            // No ACK on the last byte ends the read
                            shift    <= (byte_cnt == 4'd1) ? '1 : '0;
                            state    <= ACK_DATA;
                        end
                    end
                end
                ACK_DATA: begin
                    if (i_change) begin
                        if (byte_cnt == '0) begin
                            shift <= '0;
                            state <= STOP;
                        end else begin
                            sda_dir <= PIN_DIR_INPUT;
                            state   <= RX_DATA;
                        end
                    end
                end
                STOP: begin
                    if (i_latch) begin
                        shift <= '1;  // SDA rises under a high SCL
                        done  <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (go) begin
            payload <= {8'd0, i_ctrl.payload[PAYLOAD_W-1:8]};
        end else if (i_change && state == WAIT_ACK_DATA) begin
            payload <= {8'd0, payload[PAYLOAD_W-1:8]};
        end else if (byte_end && state == RX_DATA) begin
            payload <= {payload[PAYLOAD_W-9:0], rx_byte};
        end
        if (i_latch && state == RX_DATA) begin
            rx_byte <= {rx_byte[6:0], i_sda};  // MSB first on the wire
        end
    end

    assign o_busy    = (state != IDLE);
    assign o_sda     = shift[FRAME_W-1];
    assign o_sda_dir = sda_dir;
    assign o_done    = '{
        done:           done,
        err_ack_header: err_ack_header,
        err_ack_data:   err_ack_data,
        rx_valid:       rx_valid,
        rx_payload:     payload,
        state:          state
    };

endmodule

`default_nettype wire

//--- i2c_pkg.sv
//##################
// I2C master definitions
// Register map, engine states, pin direction and the
// bundles between register bank and protocol engine
//##################
`default_nettype none

package i2c_pkg;

    localparam int PAYLOAD_W = 32;
    localparam int FRAME_W   = 19;  // START, address, R/W, ACK slot, byte, idle bit

    typedef logic [15:0]          scale_t;     // Divider or setup count
    typedef logic [6:0]           i2c_addr_t;
    typedef logic [3:0]           byte_cnt_t;  // 0 to 4 data bytes
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // Word offsets in the APB window
    localparam logic [9:0] REG_SCLDIV  = 10'd0;
    localparam logic [9:0] REG_STATUS  = 10'd1;
    localparam logic [9:0] REG_ADDR    = 10'd2;
    localparam logic [9:0] REG_PAYLOAD = 10'd3;

    localparam logic PIN_DIR_OUTPUT = 1'b0;
    localparam logic PIN_DIR_INPUT  = 1'b1;

    typedef enum logic [7:0] {
        IDLE          = 8'd0,
        START         = 8'd1,
        HEADER        = 8'd2,
        ACK_HEADER    = 8'd3,
        TX_DATA       = 8'd4,
        WAIT_ACK_DATA = 8'd5,
        RX_DATA       = 8'd6,
        ACK_DATA      = 8'd7,
        STOP          = 8'd8
    } i2c_state_e;

    // Register bank to engine
    typedef struct packed {
        logic      start;     // One cycle
        logic      rnw;
        i2c_addr_t addr;
        byte_cnt_t byte_cnt;
        payload_t  payload;
    } i2c_ctrl_t;

    // Engine to register bank
    typedef struct packed {
        logic       done;     // One cycle on return to IDLE
        logic       err_ack_header;
        logic       err_ack_data;
        logic       rx_valid;
        payload_t   rx_payload;
        i2c_state_e state;
    } i2c_done_t;

endpackage

`default_nettype wire

//--- i2c_regs.sv
//##################
// I2C register bank
// Divider, status, address and payload registers
// with start pulse, error flags and interrupt
//##################
`default_nettype none

module i2c_regs (
    input  logic                     i_clk,
    input  logic                     i_nrst,
    input  logic                     i_req_valid,
    input  logic                     i_req_write,
    input  apb_types_pkg::apb_addr_t i_req_addr,
    input  apb_types_pkg::apb_data_t i_req_wdata,
    output logic                     o_resp_valid,
    output apb_types_pkg::apb_data_t o_resp_rdata,
    input  i2c_pkg::i2c_done_t       i_done,
    output i2c_pkg::i2c_ctrl_t       o_ctrl,
    output i2c_pkg::scale_t          o_scaler,
    output i2c_pkg::scale_t          o_setup_time,
    output logic                     o_irq,
    input  logic                     i_sda
);

    import apb_types_pkg::*;
    import i2c_pkg::*;

    scale_t     scaler;
    scale_t     setup_time;
    logic       ie;
    logic       irq;
    logic       err_ack_header;
    logic       err_ack_data;
    logic       rnw;
    byte_cnt_t  byte_cnt;
    i2c_addr_t  addr;
    payload_t   payload;
    logic       start;
    apb_data_t  rdata;
    logic [9:0] reg_sel;   // Word index
    logic       wr_en;

    assign reg_sel = i_req_addr[APB_ADDR_W-1:2];
    assign wr_en   = i_req_valid & i_req_write;

    always_comb begin
        rdata = '0;
        case (reg_sel)
            REG_SCLDIV:  rdata = {setup_time, scaler};
            REG_STATUS: begin
                rdata[7:0] = i_done.state;
                rdata[8]   = i_sda;           // Live bus level
                rdata[9]   = err_ack_header;
                rdata[10]  = err_ack_data;
                rdata[12]  = ie;
                rdata[13]  = irq;
            end
            REG_ADDR: begin
                rdata[31]    = rnw;
                rdata[19:16] = byte_cnt;
                rdata[6:0]   = addr;
            end
            REG_PAYLOAD: rdata = payload;
            default:     rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scaler         <= '0;
            setup_time     <= '0;
            ie             <= 1'b0;
            irq            <= 1'b0;
            err_ack_header <= 1'b0;
            err_ack_data   <= 1'b0;
            rnw            <= 1'b0;
            byte_cnt       <= '0;
            addr           <= '0;
            start          <= 1'b0;
            o_resp_valid   <= 1'b0;
        end else begin
            start        <= 1'b0;
            o_resp_valid <= i_req_valid;
            if (wr_en && reg_sel == REG_SCLDIV) begin
                scaler     <= i_req_wdata[15:0];
                setup_time <= i_req_wdata[31:16];
            end
            if (wr_en && reg_sel == REG_ADDR) begin
                rnw      <= i_req_wdata[31];
                byte_cnt <= i_req_wdata[19:16];
                addr     <= i_req_wdata[6:0];
                start    <= 1'b1;  // Kicks off the transfer
            end
            if (i_req_valid && reg_sel == REG_STATUS) begin
                irq <= 1'b0;  // Read or write acknowledges
            end
            if (wr_en && reg_sel == REG_STATUS) begin
                err_ack_header <= 1'b0;
                err_ack_data   <= 1'b0;
                ie             <= i_req_wdata[12];
            end
            // End of transfer wins over a clear in the same cycle
            if (i_done.done) begin
                if (ie) begin
                    irq <= 1'b1;
                end
                if (i_done.err_ack_header) begin
                    err_ack_header <= 1'b1;
                end
                if (i_done.err_ack_data) begin
                    err_ack_data <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        o_resp_rdata <= rdata;
        if (i_done.rx_valid) begin
            payload <= i_done.rx_payload;
        end else if (wr_en && reg_sel == REG_PAYLOAD) begin
            payload <= i_req_wdata;
        end
    end

    assign o_ctrl = '{
        start:    start,
        rnw:      rnw,
        addr:     addr,
        byte_cnt: byte_cnt,
        payload:  payload
    };
    assign o_scaler     = scaler;
    assign o_setup_time = setup_time;
    assign o_irq        = irq;

endmodule

`default_nettype wire

//--- i2c_target_model.sv
//##################
// I2C target model
// ACKs its own address, records written bytes
// and returns preset bytes on a read
//##################
`default_nettype none

module i2c_target_model (
    input  logic        i_scl,
    input  logic        i_sda,      // Bus level
    input  logic [6:0]  i_addr,
    input  logic [31:0] i_rd_data,  // First byte in 31:24
    output logic        o_sda       // 1 means released
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] shreg;
    logic [7:0] wr_bytes [4];
    logic       acks [4];          // Master ACK bit after each read byte
    logic [6:0] hdr_addr;
    logic       hdr_rnw;
    logic       addressed;
    logic       in_frame;
    logic       scl_q;
    logic       sda_q;
    int         bit_idx;
    int         byte_idx;          // 0 is the header
    int         wr_count;
    int         ack_count;

    initial begin
        o_sda     = 1'b1;
        in_frame  = 1'b0;
        addressed = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        wr_count  = 0;
        ack_count = 0;
        forever begin
            @(i_scl or i_sda);
            if (i_scl && !scl_q) begin
                if (in_frame && bit_idx < 8) begin
                    shreg = {shreg[6:0], i_sda};
                    if (bit_idx == 7 && byte_idx == 0) begin
                        hdr_addr  = shreg[7:1];
                        hdr_rnw   = shreg[0];
                        addressed = (shreg[7:1] == i_addr);
                    end else if (bit_idx == 7 && addressed && !hdr_rnw && wr_count < 4) begin
                        wr_bytes[wr_count] = shreg;
                        wr_count++;
                    end
                    bit_idx++;
                end else if (in_frame) begin
                    if (addressed && hdr_rnw && byte_idx > 0 && ack_count < 4) begin
                        acks[ack_count] = i_sda;
                        ack_count++;
                    end
                    bit_idx = 0;
                    byte_idx++;
                end
            end else if (!i_scl && scl_q) begin
                o_sda = 1'b1;
                if (in_frame && bit_idx == 8 && (byte_idx == 0 || (addressed && !hdr_rnw))) begin
                    o_sda = !addressed;  // ACK slot
                end else if (in_frame && bit_idx < 8 && addressed && hdr_rnw
                             && byte_idx > 0 && byte_idx <= 4) begin
                    o_sda = i_rd_data[31 - 8 * (byte_idx - 1) - bit_idx];
                end
            end else if (i_scl && scl_q && sda_q && !i_sda) begin
                in_frame  = 1'b1;  // START
                addressed = 1'b0;
                bit_idx   = 0;
                byte_idx  = 0;
                wr_count  = 0;
                ack_count = 0;
                o_sda     = 1'b1;
            end else if (i_scl && scl_q && !sda_q && i_sda) begin
                in_frame = 1'b0;   // STOP
                o_sda    = 1'b1;
            end
            scl_q = i_scl;
            sda_q = i_sda;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the apb_i2c testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_apb_i2c \
    -f apb_i2c.f -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build returned status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

//--- tb_apb_i2c.sv
//##################
// APB I2C testbench
// Register access, write, NACK and read transfers
//##################
`default_nettype none

module tb_apb_i2c;
    timeunit 1ns;
    timeprecision 100ps;

    import apb_types_pkg::*;
    import i2c_pkg::*;

    localparam int SCALER      = 10;
    localparam int SETUP       = 3;
    localparam int XFER_CYCLES = 50 * 2 * SCALER;  // One transfer in clocks
    localparam int WATCHDOG_NS = 4 * XFER_CYCLES * 8 + 20000;

    logic        i_clk;
    logic        i_nrst;
    apb_in_t     apb_in;
    apb_out_t    apb_out;
    logic        scl;
    logic        sda_out;
    logic        sda_dir;
    logic        bus_sda;
    logic        tgt_sda;
    logic        irq;
    logic [6:0]  tgt_addr;
    logic [7:0]  rd_bytes [4];
    logic [31:0] wr_word;
    logic [31:0] rdata;

    assign bus_sda = (sda_dir == PIN_DIR_INPUT) ? tgt_sda : sda_out;

    apb_i2c i_apb_i2c (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_apb(apb_in), .o_apb(apb_out),
        .o_scl(scl), .o_sda(sda_out), .o_sda_dir(sda_dir), .i_sda(bus_sda), .o_irq(irq)
    );

    i2c_target_model u_target (
        .i_scl(scl), .i_sda(bus_sda), .i_addr(tgt_addr),
        .i_rd_data({rd_bytes[0], rd_bytes[1], rd_bytes[2], rd_bytes[3]}), .o_sda(tgt_sda)
    );

    bind apb_i2c apb_i2c_sva u_sva (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_scl(o_scl), .i_sda(i_sda),
        .i_busy(u_engine.o_busy), .i_ie(u_regs.ie), .i_irq(o_irq)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else abort_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                 $time, name, got, exp));
    endtask

    function automatic apb_addr_t word_addr(input logic [9:0] idx);
        return {idx, 2'b00};
    endfunction

    task automatic apb_access(input logic write, input apb_addr_t addr,
                              input apb_data_t wdata, output apb_data_t rd);
        int waits;
        waits = 0;
        @(negedge i_clk);
        apb_in.psel    = 1'b1;  // Setup phase
        apb_in.penable = 1'b0;
        apb_in.pwrite  = write;
        apb_in.paddr   = addr;
        apb_in.pwdata  = wdata;
        @(negedge i_clk);
        apb_in.penable = 1'b1;
        do begin
            @(negedge i_clk);
            waits++;
            if (waits > 16) abort_run("APB access got no pready");
        end while (!apb_out.pready);
        check_eq("pslverr", {31'd0, apb_out.pslverr}, 32'd0);
        rd             = apb_out.prdata;
        apb_in.psel    = 1'b0;
        apb_in.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [9:0] idx, input apb_data_t wdata);
        apb_data_t unused;
        apb_access(1'b1, word_addr(idx), wdata, unused);
    endtask

    task automatic apb_read(input logic [9:0] idx, output apb_data_t rd);
        apb_access(1'b0, word_addr(idx), '0, rd);
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (!irq) begin
            @(negedge i_clk);
            n++;
            if (n > XFER_CYCLES) abort_run("transfer did not end with an interrupt");
        end
    endtask

    // Polls status until the engine is back in IDLE
    task automatic wait_idle(output apb_data_t status);
        int polls;
        polls = 0;
        do begin
            apb_read(REG_STATUS, status);
            polls++;
            if (polls > XFER_CYCLES) abort_run("transfer did not return to idle");
        end while (status[7:0] != 8'd0);
    endtask

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the test sequence finished");
    end

    always @(posedge i_clk) begin
        if (i_apb_i2c.u_sva.fail_count != 0) abort_run("bus protocol assertion failed");
    end

    initial begin
        i_nrst = 1'b0;
        apb_in = '0;
        void'($urandom(32'h8585));
        tgt_addr = 7'($urandom);
        for (int i = 0; i < 4; i++) rd_bytes[i] = 8'($urandom);
        wr_word = $urandom;
        repeat (5) @(negedge i_clk);
        i_nrst = 1'b1;

        // Register readback
        apb_read(REG_STATUS, rdata);
        check_eq("status.state", {24'd0, rdata[7:0]}, 32'd0);
        apb_write(REG_SCLDIV, {16'(SETUP), 16'(SCALER)});
        apb_read(REG_SCLDIV, rdata);
        check_eq("scldiv", rdata, {16'(SETUP), 16'(SCALER)});
        apb_write(REG_PAYLOAD, wr_word);
        apb_read(REG_PAYLOAD, rdata);
        check_eq("payload", rdata, wr_word);

        // Three byte write with ACK
        apb_write(REG_STATUS, 32'h0000_1000);
        apb_write(REG_ADDR, {12'd0, 4'd3, 9'd0, tgt_addr});
        apb_read(REG_ADDR, rdata);
        check_eq("addr", rdata, {12'd0, 4'd3, 9'd0, tgt_addr});
        wait_irq();
        check_eq("target addr", {25'd0, u_target.hdr_addr}, {25'd0, tgt_addr});
        check_eq("target rnw", {31'd0, u_target.hdr_rnw}, 32'd0);
        check_eq("target wr_count", u_target.wr_count, 32'd3);
        for (int i = 0; i < 3; i++) begin
            check_eq($sformatf("target byte %0d", i), {24'd0, u_target.wr_bytes[i]},
                     {24'd0, wr_word[8*i +: 8]});
        end
        apb_read(REG_STATUS, rdata);
        check_eq("status.state", {24'd0, rdata[7:0]}, 32'd0);
        check_eq("status.irq.ie", {30'd0, rdata[13:12]}, 32'd3);
        check_eq("status.err", {30'd0, rdata[10:9]}, 32'd0);

        // Address NACK
        apb_write(REG_ADDR, {12'd0, 4'd2, 9'd0, tgt_addr ^ 7'h01});
        wait_irq();
        check_eq("target wr_count", u_target.wr_count, 32'd0);
        check_eq("target byte_idx", u_target.byte_idx, 32'd1);  // Header only, then STOP
        apb_read(REG_STATUS, rdata);
        check_eq("status.err_ack_header", {31'd0, rdata[9]}, 32'd1);
        apb_read(REG_STATUS, rdata);
        check_eq("status.irq", {31'd0, rdata[13]}, 32'd0);
        check_eq("o_irq", {31'd0, irq}, 32'd0);

        // Four byte read
        apb_write(REG_STATUS, 32'h0000_1000);
        apb_write(REG_ADDR, {1'b1, 11'd0, 4'd4, 9'd0, tgt_addr});
        wait_irq();
        apb_read(REG_PAYLOAD, rdata);
        check_eq("rx payload", rdata, {rd_bytes[0], rd_bytes[1], rd_bytes[2], rd_bytes[3]});
        check_eq("target ack_count", u_target.ack_count, 32'd4);
        for (int i = 0; i < 4; i++) begin
            check_eq($sformatf("master ack %0d", i), {31'd0, u_target.acks[i]},
                     (i == 3) ? 32'd1 : 32'd0);
        end
        apb_read(REG_STATUS, rdata);
        check_eq("status.err", {30'd0, rdata[10:9]}, 32'd0);

        // Address only write with the interrupt disabled
        apb_write(REG_STATUS, 32'h0000_0000);
        apb_write(REG_ADDR, {12'd0, 4'd0, 9'd0, tgt_addr});
        wait_idle(rdata);
        check_eq("status.irq", {31'd0, rdata[13]}, 32'd0);
        check_eq("status.err", {30'd0, rdata[10:9]}, 32'd0);

        repeat (4) @(negedge i_clk);
        if (i_apb_i2c.u_sva.fail_count != 0) begin
            abort_run("bus protocol assertion failed");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
